// ==== project.f ====
src/ll_pkg.sv
src/ll_auto_sync.sv
src/ll_transmit.sv
src/st_master_concat.sv
src/st_master_top.sv
test/st_master_checker.sv
test/tb_st_master.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_st_master \
  -f project.f -o tb_st_master

./obj_dir/tb_st_master > sim.log 2>&1 || true
cat sim.log

grep -q "TESTBENCH PASSED" sim.log
echo "simulation passed"

// ==== src/ll_auto_sync.sv ====
`timescale 1ns/1ps

module ll_auto_sync (
  input  logic                       clk_wr,
  input  logic                       rst,
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  logic [ll_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [ll_pkg::DELAY_W-1:0] delay_y_value,
  input  logic [ll_pkg::DELAY_W-1:0] delay_z_value,
  input  logic                       tx_stb_userbit,
  input  logic                       tx_mrk_userbit,
  output logic                       tx_online_delay,
  output logic                       rx_online_delay,
  output logic                       tx_auto_stb_userbit,
  output logic                       tx_auto_mrk_userbit
);

  ////////////////////////////////////////////////////////////
  // Delay stages
  // Index 0 is tx online, 1 is rx online, 2 is the settle time

  logic [ll_pkg::NUM_DLY-1:0] dly_en;
  logic [ll_pkg::NUM_DLY-1:0] dly_lvl;
  logic [ll_pkg::DELAY_W-1:0] dly_cnt [ll_pkg::NUM_DLY];
  logic [ll_pkg::DELAY_W-1:0] dly_val [ll_pkg::NUM_DLY];
  logic                       settled;

  assign dly_val[0] = delay_x_value;
  assign dly_val[1] = delay_y_value;
  assign dly_val[2] = delay_z_value;

  // Each stage counts only while its condition holds
  assign dly_en[0] = tx_online;
  assign dly_en[1] = rx_online & dly_lvl[0];
  // Settle time starts once tx side is up
  assign dly_en[2] = dly_lvl[0];

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      dly_lvl <= '0;
      for (int i = 0; i < ll_pkg::NUM_DLY; i++) begin
        dly_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < ll_pkg::NUM_DLY; i++) begin
        if (!dly_en[i]) begin
          // Condition lost, start over
          dly_cnt[i] <= '0;
          dly_lvl[i] <= 1'b0;
        end else if (!dly_lvl[i]) begin
          // Sticky once the programmed count is reached
          if (dly_cnt[i] >= dly_val[i]) begin
            dly_lvl[i] <= 1'b1;
          end else begin
            dly_cnt[i] <= dly_cnt[i] + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs

  // Tx side falls one cycle after tx_online drops
  assign tx_online_delay = dly_lvl[0];

  // Rx side and settle drop together with their enables
  assign rx_online_delay = dly_lvl[1] & dly_en[1];
  assign settled         = dly_lvl[2] & dly_en[2];

  // Far end sees strobe and marker only on a stable link
  assign tx_auto_stb_userbit = settled & tx_stb_userbit;
  assign tx_auto_mrk_userbit = settled & tx_mrk_userbit;

endmodule

// ==== src/ll_pkg.sv ====
package ll_pkg;

  ////////////////////////////////////////////////////////////
  // Stream beat sizes
  localparam int DATA_W   = 32;
  localparam int KEEP_W   = 4;

  // One PHY word per cycle on the single channel
  localparam int PHY_W    = 40;

  // Credit return rides on the lowest bit of the receive word
  localparam int RX_CREDIT_BIT = 0;

  ////////////////////////////////////////////////////////////
  // Transmit FIFO and credit sizing
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  // Occupancy must reach FIFO_DEPTH itself
  localparam int CNT_W      = PTR_W + 1;
  localparam int CRED_W     = 8;

  // Debug word layout
  localparam int PUSHED_W = 21;
  localparam int DEBUG_W  = CRED_W + CNT_W + PUSHED_W;

  ////////////////////////////////////////////////////////////
  // Auto sync delay counters, x then y then z
  localparam int DELAY_W = 16;
  localparam int NUM_DLY = 3;

  // User beat, 37 bits
  typedef struct packed {
    logic [DATA_W-1:0] tdata;
    logic [KEEP_W-1:0] tkeep;
    logic              tlast;
  } st_beat_t;

  // Transmit PHY word, marker at the top
  typedef struct packed {
    logic     mrk;
    logic     stb;
    logic     push;
    st_beat_t beat;
  } phy_word_t;

  typedef struct packed {
    logic [CRED_W-1:0]   credit;
    logic [CNT_W-1:0]    fifo_count;
    logic [PUSHED_W-1:0] pushed_count;
  } tx_debug_t;

endpackage

// ==== src/ll_transmit.sv ====
`timescale 1ns/1ps

module ll_transmit (
  input  logic                      clk_wr,
  input  logic                      rst,
  input  logic                      tx_online,
  input  logic                      rx_online,
  input  logic [ll_pkg::CRED_W-1:0] init_credit,
  input  ll_pkg::st_beat_t          user_beat,
  input  logic                      user_valid,
  output logic                      user_ready,
  input  logic                      rx_credit,
  output ll_pkg::st_beat_t          tx_beat,
  output logic                      tx_pushbit,
  output ll_pkg::tx_debug_t         debug_status
);

  ll_pkg::st_beat_t            fifo_mem [ll_pkg::FIFO_DEPTH];
  logic [ll_pkg::PTR_W-1:0]    wr_ptr;
  logic [ll_pkg::PTR_W-1:0]    rd_ptr;
  logic [ll_pkg::CNT_W-1:0]    fifo_count;
  logic [ll_pkg::CNT_W-1:0]    fifo_count_next;
  logic [ll_pkg::CRED_W-1:0]   credit;
  logic [ll_pkg::PUSHED_W-1:0] pushed_count;
  logic                        rx_online_q;
  logic                        credit_load;
  logic                        fifo_empty;
  logic                        push;
  logic                        pop;

  ////////////////////////////////////////////////////////////
  // Pop and push control

  assign push       = user_valid & user_ready;
  assign fifo_empty = (fifo_count == '0);

  // Send only with both sides up and a credit in hand
  assign pop = tx_online & rx_online & (credit != '0) & ~fifo_empty;

  // Rising edge of the delayed rx online
  assign credit_load = rx_online & ~rx_online_q;

  always_comb begin
    case ({push, pop})
      2'b10:   fifo_count_next = fifo_count + 1'b1;
      2'b01:   fifo_count_next = fifo_count - 1'b1;
      default: fifo_count_next = fifo_count;
    endcase
  end

  // Beat FIFO, pointers wrap on the power of two depth
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
      user_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_count <= fifo_count_next;
      // Ready tracks not-full of the next occupancy
      user_ready <= (fifo_count_next != ll_pkg::FIFO_DEPTH);
    end
  end

  always_ff @(posedge clk_wr) begin
    if (push) begin
      fifo_mem[wr_ptr] <= user_beat;
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online) begin
      // Held at zero while far end is offline
      credit      <= '0;
      rx_online_q <= 1'b0;
    end else begin
      rx_online_q <= rx_online;
      if (credit_load) begin
        credit <= init_credit;
      end else begin
        // Pop and return in one cycle cancel out
        case ({pop, rx_credit})
          2'b10:   credit <= credit - 1'b1;
          2'b01:   credit <= credit + 1'b1;
          default: credit <= credit;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register, one cycle after the pop

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_pushbit   <= 1'b0;
      pushed_count <= '0;
    end else begin
      tx_pushbit <= pop;
      if (pop) begin
        pushed_count <= pushed_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (pop) begin
      tx_beat <= fifo_mem[rd_ptr];
    end
  end

  // Debug view
  assign debug_status.credit       = credit;
  assign debug_status.fifo_count   = fifo_count;
  assign debug_status.pushed_count = pushed_count;

endmodule

// ==== src/st_master_concat.sv ====
`timescale 1ns/1ps

module st_master_concat (
  input  ll_pkg::st_beat_t         tx_beat,
  input  logic                     tx_pushbit,
  input  logic                     tx_online,
  input  logic                     tx_stb_userbit,
  input  logic                     tx_mrk_userbit,
  output logic [ll_pkg::PHY_W-1:0] tx_phy,
  input  logic [ll_pkg::PHY_W-1:0] rx_phy,
  output logic                     rx_credit
);

  ////////////////////////////////////////////////////////////
  // Transmit word assembly

  ll_pkg::phy_word_t tx_word;

  always_comb begin
    // Offline link drives an all-zero word
    tx_word = '0;
    if (tx_online) begin
      tx_word.mrk  = tx_mrk_userbit;
      tx_word.stb  = tx_stb_userbit;
      tx_word.push = tx_pushbit;
      // Beat field holds the last popped beat when push is low
      tx_word.beat = tx_beat;
    end
  end

  assign tx_phy = tx_word;

  ////////////////////////////////////////////////////////////
  // Receive side, credit return only

  // One credit per cycle with the credit bit set
  // Stale credits from an offline far end are dropped
  assign rx_credit = tx_online & rx_phy[ll_pkg::RX_CREDIT_BIT];

endmodule

// ==== src/st_master_top.sv ====
`timescale 1ns/1ps

module st_master_top (
  input  logic                       clk_wr,
  input  logic                       rst,
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  logic [ll_pkg::CRED_W-1:0]  init_st_credit,
  output logic [ll_pkg::PHY_W-1:0]   tx_phy0,
  input  logic [ll_pkg::PHY_W-1:0]   rx_phy0,
  input  logic [ll_pkg::KEEP_W-1:0]  user_tkeep,
  input  logic [ll_pkg::DATA_W-1:0]  user_tdata,
  input  logic                       user_tlast,
  input  logic                       user_tvalid,
  output logic                       user_tready,
  output logic [ll_pkg::DEBUG_W-1:0] tx_st_debug_status,
  input  logic                       tx_mrk_userbit,
  input  logic                       tx_stb_userbit,
  input  logic [ll_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [ll_pkg::DELAY_W-1:0] delay_y_value,
  input  logic [ll_pkg::DELAY_W-1:0] delay_z_value
);

  ll_pkg::st_beat_t  user_beat;
  ll_pkg::st_beat_t  tx_beat;
  ll_pkg::tx_debug_t tx_debug;
  logic              tx_pushbit;
  logic              rx_credit;
  logic              tx_online_delay;
  logic              rx_online_delay;
  logic              tx_auto_stb_userbit;
  logic              tx_auto_mrk_userbit;

  // User beat packing
  assign user_beat.tdata = user_tdata;
  assign user_beat.tkeep = user_tkeep;
  assign user_beat.tlast = user_tlast;

  assign tx_st_debug_status = tx_debug;

  ////////////////////////////////////////////////////////////
  // Online delays and user bit enable

  ll_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .rst                 (rst),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  ////////////////////////////////////////////////////////////
  // Logic link transmit, runs on the delayed online levels

  ll_transmit u_transmit (
    .clk_wr       (clk_wr),
    .rst          (rst),
    .tx_online    (tx_online_delay),
    .rx_online    (rx_online_delay),
    .init_credit  (init_st_credit),
    .user_beat    (user_beat),
    .user_valid   (user_tvalid),
    .user_ready   (user_tready),
    .rx_credit    (rx_credit),
    .tx_beat      (tx_beat),
    .tx_pushbit   (tx_pushbit),
    .debug_status (tx_debug)
  );

  ////////////////////////////////////////////////////////////
  // PHY word build and credit extract

  st_master_concat u_concat (
    .tx_beat        (tx_beat),
    .tx_pushbit     (tx_pushbit),
    .tx_online      (tx_online_delay),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_phy         (tx_phy0),
    .rx_phy         (rx_phy0),
    .rx_credit      (rx_credit)
  );

endmodule

// ==== test/st_master_checker.sv ====
`timescale 1ns/1ps

module st_master_checker (
  input logic                      clk_wr,
  input logic                      rst,
  input logic                      tx_pushbit,
  input logic                      credit_load,
  input logic [ll_pkg::CRED_W-1:0] credit,
  input logic [ll_pkg::CNT_W-1:0]  fifo_count,
  input logic                      user_ready
);

  ////////////////////////////////////////////////////////////
  // Push bit only after a pop with credit and data in hand
  push_after_pop: assert property (@(posedge clk_wr) disable iff (rst)
    tx_pushbit |-> $past(credit != '0 && fifo_count != '0))
    else $error("tx_pushbit high without a pop in the previous cycle");

  // Empty credit only stays or grows until reloaded
  credit_no_wrap: assert property (@(posedge clk_wr) disable iff (rst)
    (credit == '0 && !credit_load) |=> (credit != '1))
    else $error("credit counter wrapped below zero");

  // Full FIFO holds off the user port
  ready_low_full: assert property (@(posedge clk_wr) disable iff (rst)
    (fifo_count == ll_pkg::FIFO_DEPTH) |-> !user_ready)
    else $error("user_ready high with a full FIFO");

endmodule

bind ll_transmit st_master_checker u_checker (
  .clk_wr      (clk_wr),
  .rst         (rst),
  .tx_pushbit  (tx_pushbit),
  .credit_load (credit_load),
  .credit      (credit),
  .fifo_count  (fifo_count),
  .user_ready  (user_ready)
);

// ==== test/tb_st_master.sv ====
`timescale 1ns/1ps

module tb_st_master;

  localparam int WAIT_LIMIT = 3000;
  localparam int NUM_BEATS  = 40;

  logic                       clk_wr;
  logic                       rst;
  logic                       tx_online;
  logic                       rx_online;
  logic [ll_pkg::CRED_W-1:0]  init_st_credit;
  logic [ll_pkg::PHY_W-1:0]   tx_phy0;
  logic [ll_pkg::PHY_W-1:0]   rx_phy0;
  logic [ll_pkg::KEEP_W-1:0]  user_tkeep;
  logic [ll_pkg::DATA_W-1:0]  user_tdata;
  logic                       user_tlast;
  logic                       user_tvalid;
  logic                       user_tready;
  logic [ll_pkg::DEBUG_W-1:0] tx_st_debug_status;
  logic                       tx_mrk_userbit;
  logic                       tx_stb_userbit;
  logic [ll_pkg::DELAY_W-1:0] delay_x_value;
  logic [ll_pkg::DELAY_W-1:0] delay_y_value;
  logic [ll_pkg::DELAY_W-1:0] delay_z_value;

  ll_pkg::phy_word_t phy;
  ll_pkg::tx_debug_t dbg;
  ll_pkg::st_beat_t  beat_in;
  ll_pkg::st_beat_t  exp_q [$];

  integer seed;
  integer far_seed;
  int     errors;
  int     checks;
  int     test_errors;
  int     accept_cnt;
  int     push_cnt;
  int     returned;
  int     load_push;
  int     load_ret;
  int     guard;
  // Consecutive edges with each delay stage enabled
  int     run_x;
  int     run_y;
  int     run_z;
  logic   m_txd;
  logic   m_rxd;
  logic   m_set;
  logic   prev_rxd;
  logic   ret_en;
  logic   ret_next;

  assign phy = tx_phy0;
  assign dbg = tx_st_debug_status;

  st_master_top u_dut (.*);

  initial begin
    clk_wr = 1'b0;
    forever #2 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic step();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    $display("test %-14s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("%0t: timed out waiting for %s", $time, what);
    finish_run();
  endtask

  // One beat with an optional random idle gap in front
  task automatic send_beat(input bit gaps);
    int target;
    int wait_cnt;
    if (gaps) begin
      user_tvalid = 1'b0;
      repeat ($unsigned($random(seed)) % 3) step();
    end
    user_tdata  = $random(seed);
    user_tkeep  = 4'($random(seed));
    user_tlast  = 1'($random(seed));
    user_tvalid = 1'b1;
    target      = accept_cnt + 1;
    wait_cnt    = 0;
    do begin
      step();
      wait_cnt++;
    end while (accept_cnt < target && wait_cnt < WAIT_LIMIT);
    if (accept_cnt < target) report_timeout("user_tready on a beat");
    user_tvalid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Model, scoreboard and far end

  always @(posedge clk_wr) begin
    if (rst) begin
      run_x    = 0;
      run_y    = 0;
      run_z    = 0;
      prev_rxd = 1'b0;
      ret_next = 1'b0;
    end else begin
      // Levels the DUT holds in the cycle ending here
      m_txd = (run_x > int'(delay_x_value));
      m_rxd = m_txd && rx_online && (run_y > int'(delay_y_value));
      m_set = m_txd && (run_z > int'(delay_z_value));
      if (!m_txd) begin
        check("tx_phy0", '0, tx_phy0);
      end else begin
        check("tx_phy0.stb", m_set & tx_stb_userbit, phy.stb);
        check("tx_phy0.mrk", m_set & tx_mrk_userbit, phy.mrk);
      end
      if (phy.push) begin
        push_cnt++;
        if (!prev_rxd) begin
          report_error("push on tx_phy0 before the rx side came online");
        end
        if (exp_q.size() == 0) begin
          report_error("push on tx_phy0 with no accepted beat pending");
        end else begin
          check("tx_phy0.beat", exp_q.pop_front(), phy.beat);
        end
      end
      if (user_tvalid && user_tready) begin
        beat_in.tdata = user_tdata;
        beat_in.tkeep = user_tkeep;
        beat_in.tlast = user_tlast;
        exp_q.push_back(beat_in);
        accept_cnt++;
      end
      // Far end never returns more credits than words seen
      ret_next = ret_en && (push_cnt > returned) && ($random(far_seed) % 2 != 0);
      if (ret_next) begin
        returned++;
      end
      prev_rxd = m_rxd;
      run_x    = tx_online ? run_x + 1 : 0;
      run_y    = (rx_online && m_txd) ? run_y + 1 : 0;
      run_z    = m_txd ? run_z + 1 : 0;
    end
  end

  // Credit return word
  initial begin
    rx_phy0 = '0;
    forever begin
      step();
      rx_phy0 = '0;
      rx_phy0[ll_pkg::RX_CREDIT_BIT] = ret_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed           = 32'h6676;
    far_seed       = 32'h6676;
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_st_credit = '0;
    user_tkeep     = '0;
    user_tdata     = '0;
    user_tlast     = 1'b0;
    user_tvalid    = 1'b0;
    tx_mrk_userbit = 1'b0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = '0;
    delay_y_value  = '0;
    delay_z_value  = '0;
    ret_en         = 1'b0;
    repeat (8) @(posedge clk_wr);
    #1;
    rst = 1'b0;

    // Model checks tx_phy0 gating every cycle
    delay_x_value  = 16'($unsigned($random(seed)) % 16);
    delay_y_value  = 16'($unsigned($random(seed)) % 16);
    delay_z_value  = 16'($unsigned($random(seed)) % 16);
    init_st_credit = 8'(3 + $unsigned($random(seed)) % 8);
    tx_stb_userbit = 1'b1;
    tx_mrk_userbit = 1'b1;
    tx_online      = 1'b1;
    rx_online      = 1'b1;
    load_push      = push_cnt;
    load_ret       = returned;
    guard          = 0;
    while (dbg.credit != init_st_credit && guard < WAIT_LIMIT) begin
      step();
      guard++;
    end
    if (guard >= WAIT_LIMIT) report_timeout("the initial credit load");
    end_test("online_gating");

    // FIFO fills behind the spent credit when nothing returns
    repeat (init_st_credit + ll_pkg::FIFO_DEPTH) send_beat(1'b0);
    repeat (6) step();
    check("pushed words", init_st_credit, push_cnt - load_push);
    check("user_tready", 1'b0, user_tready);
    check("debug credit", 0, dbg.credit);
    check("debug fifo_count", ll_pkg::FIFO_DEPTH, dbg.fifo_count);
    end_test("credit_limit");

    ret_en = 1'b1;
    repeat (NUM_BEATS) send_beat(1'b1);
    guard = 0;
    while (exp_q.size() != 0 && guard < WAIT_LIMIT) begin
      step();
      guard++;
    end
    if (guard >= WAIT_LIMIT) report_timeout("the beat queue to drain");
    end_test("data_integrity");

    // Let the last return land before comparing counts
    ret_en = 1'b0;
    repeat (3) step();
    check("debug credit", init_st_credit + (returned - load_ret) - accept_cnt,
          dbg.credit);
    check("debug pushed_count", accept_cnt % (1 << ll_pkg::PUSHED_W), dbg.pushed_count);
    check("debug fifo_count", 0, dbg.fifo_count);
    end_test("credit_return");

    guard = 0;
    while (m_set !== 1'b1 && guard < WAIT_LIMIT) begin
      step();
      guard++;
    end
    if (guard >= WAIT_LIMIT) report_timeout("the settle point");
    repeat (20) begin
      tx_stb_userbit = 1'($random(seed));
      tx_mrk_userbit = 1'($random(seed));
      step();
    end
    end_test("user_bits");

    // Queue three beats while offline and reconnect
    tx_online = 1'b0;
    step();
    check("tx_phy0 offline", '0, tx_phy0);
    load_push = push_cnt;
    repeat (3) send_beat(1'b0);
    repeat (2) step();
    check("pushes while offline", 0, push_cnt - load_push);
    check("debug credit offline", 0, dbg.credit);
    tx_online = 1'b1;
    guard     = 0;
    while (exp_q.size() != 0 && guard < WAIT_LIMIT) begin
      step();
      guard++;
    end
    if (guard >= WAIT_LIMIT) report_timeout("pushing to resume after reconnect");
    repeat (3) step();
    check("pushes after reconnect", 3, push_cnt - load_push);
    check("debug credit", init_st_credit - 3, dbg.credit);
    end_test("offline");

    finish_run();
  end

endmodule
